//--- common/mips_isa_pkg.sv
// ---------------------------------------------------------------------------
// mips instruction set definitions for the execute unit
// word and field widths, opcode and funct codes
// packed instruction word with r-type and i-type views
// ---------------------------------------------------------------------------

package mips_isa_pkg;

   // data path and instruction word width
   localparam int word_w     = 32;
   // register number field, also the width of the shamt field
   localparam int reg_addr_w = 5;
   localparam int opcode_w   = 6;
   localparam int funct_w    = 6;
   // immediate field of i-type words
   localparam int imm_w      = 16;

   // primary opcodes
   localparam logic [opcode_w-1:0] op_rtype = 6'd0;
   localparam logic [opcode_w-1:0] op_addi  = 6'd8;
   localparam logic [opcode_w-1:0] op_addiu = 6'd9;
   localparam logic [opcode_w-1:0] op_andi  = 6'd12;
   localparam logic [opcode_w-1:0] op_ori   = 6'd13;
   localparam logic [opcode_w-1:0] op_xori  = 6'd14;

   // funct codes, only meaningful under op_rtype
   localparam logic [funct_w-1:0] fn_sll  = 6'd0;
   localparam logic [funct_w-1:0] fn_srl  = 6'd2;
   localparam logic [funct_w-1:0] fn_sra  = 6'd3;
   localparam logic [funct_w-1:0] fn_add  = 6'd32;
   localparam logic [funct_w-1:0] fn_addu = 6'd33;
   localparam logic [funct_w-1:0] fn_sub  = 6'd34;
   localparam logic [funct_w-1:0] fn_subu = 6'd35;
   localparam logic [funct_w-1:0] fn_and  = 6'd36;
   localparam logic [funct_w-1:0] fn_or   = 6'd37;
   localparam logic [funct_w-1:0] fn_xor  = 6'd38;

   // one 32-bit word, read as r-type or as i-type depending on opcode
   typedef union packed {
      struct packed {
         logic [opcode_w-1:0]   opcode;
         logic [reg_addr_w-1:0] rs;
         logic [reg_addr_w-1:0] rt;
         logic [reg_addr_w-1:0] rd;
         logic [reg_addr_w-1:0] shamt;
         logic [funct_w-1:0]    funct;
      } r;
      struct packed {
         logic [opcode_w-1:0]   opcode;
         logic [reg_addr_w-1:0] rs;
         logic [reg_addr_w-1:0] rt;
         logic [imm_w-1:0]      imm;
      } i;
   } insn_word_t;

endpackage

//--- common/alu_pkg.sv
// ---------------------------------------------------------------------------
// alu datapath definitions
// select field width, operation select codes, shift amount width
// ---------------------------------------------------------------------------

package alu_pkg;

   // width of the operation select from the decoder
   localparam int alu_sel_w = 4;

   // arithmetic, carry out on add and borrow on sub
   localparam logic [alu_sel_w-1:0] alu_add = 4'd0;
   localparam logic [alu_sel_w-1:0] alu_sub = 4'd1;

   // bitwise logic
   localparam logic [alu_sel_w-1:0] alu_and = 4'd2;
   localparam logic [alu_sel_w-1:0] alu_or  = 4'd3;
   localparam logic [alu_sel_w-1:0] alu_xor = 4'd4;

   // shifts move op_b by the low bits of op_a
   localparam logic [alu_sel_w-1:0] alu_sll = 4'd5;
   localparam logic [alu_sel_w-1:0] alu_srl = 4'd6;
   localparam logic [alu_sel_w-1:0] alu_sra = 4'd7;

   // number of operand bits a shift looks at
   localparam int shamt_w = 5;

endpackage

//--- src/insn_decoder.sv
// ---------------------------------------------------------------------------
// insn_decoder: combinational instruction decode for the execute unit
// maps opcode/funct to an alu select, builds both alu operands
// sign or zero extends the immediate, flags unsupported encodings
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module insn_decoder (
   input  mips_isa_pkg::insn_word_t                  instr,
   input  logic [mips_isa_pkg::word_w-1:0]           rs_val,
   input  logic [mips_isa_pkg::word_w-1:0]           rt_val,
   output logic [alu_pkg::alu_sel_w-1:0]             alu_sel,
   output logic [mips_isa_pkg::word_w-1:0]           op_a,
   output logic [mips_isa_pkg::word_w-1:0]           op_b,
   output logic                                      illegal
);
   import mips_isa_pkg::*;
   import alu_pkg::*;

   logic [word_w-1:0] se_imm;
   logic [word_w-1:0] ze_imm;
   logic [word_w-1:0] shamt_ext;

   // addi/addiu take the immediate as signed
   assign se_imm    = {{(word_w-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};
   // logical immediates are always zero extended
   assign ze_imm    = {{(word_w-imm_w){1'b0}}, instr.i.imm};
   assign shamt_ext = {{(word_w-reg_addr_w){1'b0}}, instr.r.shamt};

   always_comb begin
      // defaults match the illegal response
      alu_sel = alu_add;
      op_a    = '0;
      op_b    = '0;
      illegal = 1'b0;

      case (instr.r.opcode)
         op_rtype: begin
            op_a = rs_val;
            op_b = rt_val;
            case (instr.r.funct)
               // shifts ignore rs, amount comes from the word itself
               fn_sll: begin
                  alu_sel = alu_sll;
                  op_a    = shamt_ext;
               end
               fn_srl: begin
                  alu_sel = alu_srl;
                  op_a    = shamt_ext;
               end
               fn_sra: begin
                  alu_sel = alu_sra;
                  op_a    = shamt_ext;
               end
               // signed and unsigned forms share one adder
               fn_add, fn_addu: alu_sel = alu_add;
               fn_sub, fn_subu: alu_sel = alu_sub;
               fn_and:          alu_sel = alu_and;
               fn_or:           alu_sel = alu_or;
               fn_xor:          alu_sel = alu_xor;
               default: begin
                  illegal = 1'b1;
                  op_a    = '0;
                  op_b    = '0;
               end
            endcase
         end
         op_addi, op_addiu: begin
            alu_sel = alu_add;
            op_a    = rs_val;
            op_b    = se_imm;
         end
         op_andi: begin
            alu_sel = alu_and;
            op_a    = rs_val;
            op_b    = ze_imm;
         end
         op_ori: begin
            alu_sel = alu_or;
            op_a    = rs_val;
            op_b    = ze_imm;
         end
         op_xori: begin
            alu_sel = alu_xor;
            op_a    = rs_val;
            op_b    = ze_imm;
         end
         // anything else, incl. branches, loads, jumps
         default: illegal = 1'b1;
      endcase
   end

endmodule

//--- alu/mips_alu.sv
// ---------------------------------------------------------------------------
// mips_alu: combinational alu for the execute unit
// add/sub with carry and borrow, and/or/xor, sll/srl/sra
// zero, carry and negative flags
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module mips_alu (
   input  logic [alu_pkg::alu_sel_w-1:0]   alu_sel,
   input  logic [mips_isa_pkg::word_w-1:0] op_a,
   input  logic [mips_isa_pkg::word_w-1:0] op_b,
   output logic [mips_isa_pkg::word_w-1:0] result,
   output logic                            zero,
   output logic                            carry,
   output logic                            neg
);
   import mips_isa_pkg::*;
   import alu_pkg::*;

   // one extra bit holds carry out or borrow
   logic [word_w:0]    wide;
   logic [shamt_w-1:0] sh;

   // shifts only look at the low bits of op_a
   assign sh = op_a[shamt_w-1:0];

   always_comb begin
      wide   = '0;
      result = '0;
      carry  = 1'b0;
      case (alu_sel)
         alu_add: begin
            wide   = {1'b0, op_a} + {1'b0, op_b};
            result = wide[word_w-1:0];
            carry  = wide[word_w];
         end
         alu_sub: begin
            // top bit set when op_b > op_a, i.e. a borrow
            wide   = {1'b0, op_a} - {1'b0, op_b};
            result = wide[word_w-1:0];
            carry  = wide[word_w];
         end
         alu_and: result = op_a & op_b;
         alu_or:  result = op_a | op_b;
         alu_xor: result = op_a ^ op_b;
         alu_sll: result = op_b << sh;
         alu_srl: result = op_b >> sh;
         // arithmetic shift keeps the sign of op_b
         alu_sra: result = $unsigned($signed(op_b) >>> sh);
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);
   // plain sign bit, no overflow correction
   assign neg  = result[word_w-1];

   // the decoder only ever hands over codes 0..7
   always_comb begin
      sel_in_range: assert final (!$isunknown(alu_sel) && (alu_sel < 4'd8))
         else $error("alu select %0h out of range", alu_sel);
   end

endmodule

//--- src/exec_unit.sv
// ---------------------------------------------------------------------------
// exec_unit: execute half of a single-cycle mips core
// four-phase req/ack control, operand capture, response registers
// instances of insn_decoder and mips_alu, handshake assertions
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module exec_unit (
   input  logic                            clk,
   input  logic                            rst_b,
   input  logic                            req,
   input  mips_isa_pkg::insn_word_t        instr,
   input  logic [mips_isa_pkg::word_w-1:0] rs_val,
   input  logic [mips_isa_pkg::word_w-1:0] rt_val,
   output logic                            ack,
   output logic [mips_isa_pkg::word_w-1:0] result,
   output logic                            zero,
   output logic                            carry,
   output logic                            neg,
   output logic                            illegal
);
   import mips_isa_pkg::*;
   import alu_pkg::*;

   // captured request
   insn_word_t           instr_q;
   logic [word_w-1:0]    rs_q;
   logic [word_w-1:0]    rt_q;
   // controller state: busy for the compute cycle, ack while done
   logic                 busy;
   logic                 accept;
   logic [alu_sel_w-1:0] alu_sel;
   logic [word_w-1:0]    op_a;
   logic [word_w-1:0]    op_b;
   logic [word_w-1:0]    alu_result;
   logic                 alu_zero;
   logic                 alu_carry;
   logic                 alu_neg;
   logic                 dec_illegal;

   // new request only when fully idle
   assign accept = req && !ack && !busy;

   // idle -> busy -> done(ack) -> idle once req is seen low
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         busy <= 1'b0;
         ack  <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (busy) begin
         busy <= 1'b0;
         ack  <= 1'b1;
      end else if (ack && !req) begin
         ack <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         instr_q <= '0;
      end else if (accept) begin
         instr_q <= instr;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rs_q <= rs_val;
         rt_q <= rt_val;
      end
   end

   insn_decoder u_dec (
      .instr   (instr_q),
      .rs_val  (rs_q),
      .rt_val  (rt_q),
      .alu_sel (alu_sel),
      .op_a    (op_a),
      .op_b    (op_b),
      .illegal (dec_illegal)
   );

   mips_alu u_alu (
      .alu_sel (alu_sel),
      .op_a    (op_a),
      .op_b    (op_b),
      .result  (alu_result),
      .zero    (alu_zero),
      .carry   (alu_carry),
      .neg     (alu_neg)
   );

   // response loads in the busy cycle, then holds until the next one
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         result  <= '0;
         zero    <= 1'b0;
         carry   <= 1'b0;
         neg     <= 1'b0;
         illegal <= 1'b0;
      end else if (busy) begin
         // illegal words return all zeros, zero flag too
         result  <= dec_illegal ? '0 : alu_result;
         zero    <= alu_zero && !dec_illegal;
         carry   <= alu_carry && !dec_illegal;
         neg     <= alu_neg && !dec_illegal;
         illegal <= dec_illegal;
      end
   end

   // ack may only come up for a request that was still being held
   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_b)
      $rose(ack) |-> $past(req));

   // requester keeps the word steady until it sees ack
   instr_held: assert property (@(posedge clk) disable iff (!rst_b)
      (req && !ack) |=> (!req || ack || $stable(instr)));

   // release follows the requester, req stays down until ack is seen low
   ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_b)
      $fell(ack) |-> !req);

endmodule

//--- tests/tb_exec_unit.sv
// ---------------------------------------------------------------------------
// testbench for exec_unit
// galois lfsr stimulus, reference model of the decode and alu rules
// four-phase request driver with timeouts, value checker
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_exec_unit;
   import mips_isa_pkg::*;

   localparam int n_req   = 400;
   localparam int tmo_cyc = 20;

   logic        clk;
   logic        rst_b;
   logic        req;
   logic [31:0] instr;
   logic [31:0] rs_val;
   logic [31:0] rt_val;
   logic        ack;
   logic [31:0] result;
   logic        zero;
   logic        carry;
   logic        neg;
   logic        illegal;

   logic [31:0] lfsr;
   int          errors;
   int          timeouts;

   exec_unit u_dut (
      .clk     (clk),
      .rst_b   (rst_b),
      .req     (req),
      .instr   (instr),
      .rs_val  (rs_val),
      .rt_val  (rt_val),
      .ack     (ack),
      .result  (result),
      .zero    (zero),
      .carry   (carry),
      .neg     (neg),
      .illegal (illegal)
   );

   // 40 ns period
   initial clk = 1'b0;
   always #20 clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1, right shifting galois form
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken, lsb first
   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v[k] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // supported encodings as {opcode, funct}, funct unused for i-type
   function automatic logic [11:0] legal_enc(input int idx);
      case (idx)
         0:       legal_enc = {op_rtype, fn_sll};
         1:       legal_enc = {op_rtype, fn_srl};
         2:       legal_enc = {op_rtype, fn_sra};
         3:       legal_enc = {op_rtype, fn_add};
         4:       legal_enc = {op_rtype, fn_addu};
         5:       legal_enc = {op_rtype, fn_sub};
         6:       legal_enc = {op_rtype, fn_subu};
         7:       legal_enc = {op_rtype, fn_and};
         8:       legal_enc = {op_rtype, fn_or};
         9:       legal_enc = {op_rtype, fn_xor};
         10:      legal_enc = {op_addi, 6'd0};
         11:      legal_enc = {op_addiu, 6'd0};
         12:      legal_enc = {op_andi, 6'd0};
         13:      legal_enc = {op_ori, 6'd0};
         default: legal_enc = {op_xori, 6'd0};
      endcase
   endfunction

   // expected response straight from the instruction set rules
   task automatic model(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
                        output logic [31:0] res, output logic z, output logic c,
                        output logic n, output logic ill);
      logic [5:0]  opc;
      logic [5:0]  fn;
      logic [4:0]  sh;
      logic [31:0] sx;
      logic [31:0] zx;
      logic [32:0] sum;
      opc = w[31:26];
      fn  = w[5:0];
      sh  = w[10:6];
      sx  = {{16{w[15]}}, w[15:0]};
      zx  = {16'h0000, w[15:0]};
      res = 32'h0;
      c   = 1'b0;
      ill = 1'b0;
      if (opc == op_rtype) begin
         // shifts take rt and shamt, rs plays no part
         if (fn == fn_sll) res = b << sh;
         else if (fn == fn_srl) res = b >> sh;
         else if (fn == fn_sra) res = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
         else if (fn == fn_add || fn == fn_addu) begin
            sum = {1'b0, a} + {1'b0, b};
            res = sum[31:0];
            c   = sum[32];
         end else if (fn == fn_sub || fn == fn_subu) begin
            res = a - b;
            // borrow
            c   = (b > a);
         end else if (fn == fn_and) res = a & b;
         else if (fn == fn_or) res = a | b;
         else if (fn == fn_xor) res = a ^ b;
         else ill = 1'b1;
      end else if (opc == op_addi || opc == op_addiu) begin
         sum = {1'b0, a} + {1'b0, sx};
         res = sum[31:0];
         c   = sum[32];
      end else if (opc == op_andi) res = a & zx;
      else if (opc == op_ori) res = a | zx;
      else if (opc == op_xori) res = a ^ zx;
      else ill = 1'b1;
      // illegal words answer with everything 0
      z = !ill && (res == 32'h0);
      n = !ill && res[31];
   endtask

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_response(input string tag, input logic [31:0] er, input logic ez,
                                 input logic ec, input logic en, input logic ei);
      check_val({tag, " result"}, result, er);
      check_val({tag, " zero"}, 32'(zero), 32'(ez));
      check_val({tag, " carry"}, 32'(carry), 32'(ec));
      check_val({tag, " neg"}, 32'(neg), 32'(en));
      check_val({tag, " illegal"}, 32'(illegal), 32'(ei));
   endtask

   // counts falling edges until ack reaches lvl
   task automatic wait_ack(input logic lvl, output int cycles);
      @(negedge clk);
      cycles = 1;
      while (ack !== lvl && cycles < tmo_cyc) begin
         @(negedge clk);
         cycles++;
      end
      if (ack !== lvl) begin
         timeouts++;
         $display("handshake stalled: ack did not reach %0d within %0d cycles (time %0t)",
                  lvl, tmo_cyc, $time);
      end
   endtask

   task automatic make_request(output logic [31:0] w, output logic [31:0] a,
                               output logic [31:0] b);
      logic [31:0] r;
      logic [11:0] enc;
      draw(32, w);
      draw(32, a);
      draw(32, b);
      draw(3, r);
      if (r[2:0] == 3'd0) begin
         // mostly unsupported, any opcode and any funct
         draw(6, r);
         w[31:26] = r[5:0];
         draw(6, r);
         w[5:0] = r[5:0];
      end else begin
         draw(4, r);
         enc = legal_enc(int'(r[3:0]) % 15);
         w[31:26] = enc[11:6];
         if (enc[11:6] == op_rtype) w[5:0] = enc[5:0];
      end
      // equal operands now and then, so sub lands on zero
      draw(2, r);
      if (r[1:0] == 2'd0) b = a;
   endtask

   task automatic run_request(input int idx);
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] er;
      logic        ez;
      logic        ec;
      logic        en;
      logic        ei;
      int          cycles;
      int          hold;
      string       tag;
      tag = $sformatf("req %0d", idx);
      make_request(w, a, b);
      model(w, a, b, er, ez, ec, en, ei);
      draw(2, r);
      hold = int'(r[1:0]);
      @(posedge clk);
      req    <= 1'b1;
      instr  <= w;
      rs_val <= a;
      rt_val <= b;
      wait_ack(1'b1, cycles);
      // drive edge, capture edge, then ack on the next one
      check_val({tag, " ack latency"}, 32'(cycles), 32'd3);
      check_response(tag, er, ez, ec, en, ei);
      // back-pressure, response must hold
      for (int k = 0; k < hold; k++) begin
         @(negedge clk);
         check_val({tag, " ack while held"}, 32'(ack), 32'd1);
         check_response({tag, " held"}, er, ez, ec, en, ei);
      end
      @(posedge clk);
      req <= 1'b0;
      // junk on the bus once req is low, not to be captured
      draw(32, r);
      instr <= r;
      wait_ack(1'b0, cycles);
      check_val({tag, " ack release"}, 32'(cycles), 32'd2);
   endtask

   initial begin
      lfsr     = 32'hada3_a29a;
      errors   = 0;
      timeouts = 0;
      rst_b  <= 1'b0;
      req    <= 1'b0;
      instr  <= '0;
      rs_val <= '0;
      rt_val <= '0;
      repeat (5) @(posedge clk);
      rst_b <= 1'b1;
      // idle response straight out of reset
      @(negedge clk);
      check_val("ack after reset", 32'(ack), 32'd0);
      check_response("after reset", 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
      for (int i = 0; i < n_req; i++) begin
         run_request(i);
      end
      $display("value errors %0d, handshake timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- mips_exec.f
common/mips_isa_pkg.sv
common/alu_pkg.sv
src/insn_decoder.sv
alu/mips_alu.sv
src/exec_unit.sv
tests/tb_exec_unit.sv

//--- Makefile
# Verilator build and run of the mips execute unit testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_exec_unit
FILELIST = mips_exec.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
